// ==== common/hyperbus_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared HyperBus constants and structs
// one 16-bit bus word per clk0 cycle
// FIFO_DEPTH must be a power of two
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package hyperbus_pkg;

    localparam int NR_CS       = 2;
    localparam int BURST_WIDTH = 12;
    localparam int WORD_WIDTH  = 16;
    localparam int CA_WORDS    = 3;
    localparam int FIFO_DEPTH  = 4;

    localparam int PTR_WIDTH   = $clog2(FIFO_DEPTH);
    localparam int SPACE_WIDTH = $clog2(FIFO_DEPTH + 1);
    localparam int RX_RESERVE  = 2; // free rx entries kept for words in flight

    // timing configuration, static outside idle
    typedef struct packed {
        logic [3:0]  t_latency;   // clocked wait cycles, doubled on rwds
        logic [3:0]  t_rwr;
        logic [15:0] t_cs_max;
        logic [3:0]  rwds_ignore; // reserved
    } cfg_t;

    typedef struct packed {
        logic [31:0]            address; // word address
        logic [NR_CS-1:0]       cs;      // one-hot
        logic                   write;
        logic [BURST_WIDTH-1:0] burst;   // number of words
        logic                   wrapped;
    } trans_t;

    typedef struct packed {
        logic [WORD_WIDTH-1:0] data;
        logic [1:0]            strb; // set bit writes the byte
    } tx_word_t;

    typedef struct packed {
        logic [WORD_WIDTH-1:0] data;
        logic                  last;
        logic                  error;
    } rx_word_t;

    // pins towards the pad ring
    typedef struct packed {
        logic [NR_CS-1:0]      cs_n;
        logic                  ck_en;
        logic [WORD_WIDTH-1:0] dq;
        logic                  dq_oe;
        logic [1:0]            rwds; // byte mask, high means masked
        logic                  rwds_oe;
    } bus_out_t;

    typedef struct packed {
        logic [WORD_WIDTH-1:0] dq;
        logic                  rwds;
    } bus_in_t;

endpackage

// ==== hw/hyperbus_word_fifo.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fall-through word FIFO, no added latency
// flush drops all entries, blocks push/pop
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module hyperbus_word_fifo #(
    parameter type payload_t = logic [hyperbus_pkg::WORD_WIDTH-1:0]
) (
    input  logic                                 clk0,
    input  logic                                 rst_ni,
    input  logic                                 flush_i,
    input  logic                                 push_valid_i,
    output logic                                 push_ready_o,
    input  payload_t                             push_data_i,
    output logic                                 pop_valid_o,
    input  logic                                 pop_ready_i,
    output payload_t                             pop_data_o,
    output logic [hyperbus_pkg::SPACE_WIDTH-1:0] space_o
);

    localparam int DEPTH = hyperbus_pkg::FIFO_DEPTH;
    localparam int CW    = hyperbus_pkg::SPACE_WIDTH;

    payload_t                           mem_q [DEPTH];
    logic [hyperbus_pkg::PTR_WIDTH-1:0] wr_ptr_q, rd_ptr_q;
    logic [CW-1:0]                      count_q;
    logic                               push, pop;

    assign push_ready_o = !flush_i && count_q != CW'(DEPTH);
    assign pop_valid_o  = !flush_i && count_q != '0;
    assign push         = push_valid_i && push_ready_o;
    assign pop          = pop_valid_o && pop_ready_i;
    assign pop_data_o   = mem_q[rd_ptr_q];
    assign space_o      = CW'(DEPTH) - count_q;

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1; // wraps, depth is 2^n
            if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
            count_q <= count_q + CW'(push) - CW'(pop);
        end
    end

    always_ff @(posedge clk0) begin
        if (push) mem_q[wr_ptr_q] <= push_data_i;
    end

    // no overflow, count and pointers agree
    assert property (@(posedge clk0) disable iff (!rst_ni)
        count_q <= CW'(DEPTH) && count_q[hyperbus_pkg::PTR_WIDTH-1:0] == wr_ptr_q - rd_ptr_q);
    // no underflow, pointers only meet when empty or full
    assert property (@(posedge clk0) disable iff (!rst_ni)
        pop |-> wr_ptr_q != rd_ptr_q || count_q == CW'(DEPTH));

endmodule

// ==== hw/hyperbus_ca_gen.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// command-address for memory space only
// word 0 is the most significant
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module hyperbus_ca_gen (
    input  hyperbus_pkg::trans_t                trans_i,
    input  logic [1:0]                          word_sel_i,
    output logic [hyperbus_pkg::WORD_WIDTH-1:0] ca_word_o
);

    localparam int W = hyperbus_pkg::WORD_WIDTH;

    logic [hyperbus_pkg::CA_WORDS*W-1:0] ca;

    always_comb begin
        ca        = '0;
        ca[47]    = ~trans_i.write;   // read
        ca[46]    = 1'b0;             // memory space
        ca[45]    = ~trans_i.wrapped; // linear burst
        ca[44:16] = trans_i.address[31:3];
        ca[2:0]   = trans_i.address[2:0];
    end

    always_comb begin
        case (word_sel_i)
            2'd0:    ca_word_o = ca[3*W-1:2*W];
            2'd1:    ca_word_o = ca[2*W-1:W];
            2'd2:    ca_word_o = ca[W-1:0];
            default: ca_word_o = '0;
        endcase
    end

endmodule

// ==== hyperbus_ctrl/hyperbus_ctrl.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// transaction FSM of the HyperBus PHY
// needs t_latency >= 1, t_cs_max >= 1
// trans_i.cs must be one-hot
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module hyperbus_ctrl (
    input  logic                                 clk0,
    input  logic                                 rst_ni,
    input  hyperbus_pkg::cfg_t                   cfg_i,

    input  logic                                 trans_valid_i,
    output logic                                 trans_ready_o,
    input  hyperbus_pkg::trans_t                 trans_i,
    output hyperbus_pkg::trans_t                 trans_o,

    output logic [1:0]                           ca_word_sel_o,
    input  logic [hyperbus_pkg::WORD_WIDTH-1:0]  ca_word_i,

    input  logic                                 txq_valid_i,
    output logic                                 txq_ready_o,
    input  hyperbus_pkg::tx_word_t               txq_word_i,
    output logic                                 txq_flush_o,

    output logic                                 rxq_push_o,
    output hyperbus_pkg::rx_word_t               rxq_word_o,
    input  logic [hyperbus_pkg::SPACE_WIDTH-1:0] rxq_space_i,

    output logic                                 b_valid_o,
    output logic                                 b_error_o,

    output hyperbus_pkg::bus_out_t               bus_o,
    input  hyperbus_pkg::bus_in_t                bus_i
);

    typedef enum logic [2:0] {
        ST_IDLE, ST_CMD, ST_LAT, ST_DATA, ST_STALL, ST_ERR, ST_REC
    } state_e;

    state_e state_q, state_d;

    hyperbus_pkg::trans_t                 trans_q;
    logic [hyperbus_pkg::NR_CS-1:0]       cs_n_q;
    logic [15:0]                          cs_timer_q;
    logic [4:0]                           lat_cnt_q;
    logic [hyperbus_pkg::BURST_WIDTH-1:0] beat_cnt_q; // data cycles still to clock
    logic [hyperbus_pkg::BURST_WIDTH-1:0] word_cnt_q; // words still to deliver
    logic [3:0]                           rwr_cnt_q;
    logic                                 b_valid_q;
    logic                                 b_error_q;

    logic cs_active;
    logic expire;
    logic last_word;
    logic data_go;
    logic word_fire;

    assign cs_active = ~&cs_n_q;
    assign expire    = cs_active && cs_timer_q == 16'd1;
    assign last_word = word_cnt_q == hyperbus_pkg::BURST_WIDTH'(1);

    // a data cycle may go out: tx word present, or room for the read reply
    assign data_go = trans_q.write ? txq_valid_i
                   : (int'(rxq_space_i) > hyperbus_pkg::RX_RESERVE && beat_cnt_q != '0);

    assign word_fire = rxq_push_o || (txq_ready_o && txq_valid_i);

    assign trans_o   = trans_q;
    assign b_valid_o = b_valid_q;
    assign b_error_o = b_error_q;

    // tx side only accepts words inside a write burst
    assign txq_flush_o = !trans_q.write || state_q == ST_IDLE || state_q == ST_REC;

    always_comb begin
        state_d          = state_q;
        trans_ready_o    = 1'b0;
        txq_ready_o      = 1'b0;
        rxq_push_o       = 1'b0;
        rxq_word_o.data  = bus_i.dq;
        rxq_word_o.last  = last_word;
        rxq_word_o.error = 1'b0;
        bus_o            = '0;
        bus_o.cs_n       = cs_n_q;

        case (state_q)
            ST_IDLE: begin
                trans_ready_o = 1'b1;
                if (trans_valid_i) state_d = ST_CMD;
            end
            ST_CMD: begin
                bus_o.ck_en = 1'b1;
                bus_o.dq    = ca_word_i;
                bus_o.dq_oe = 1'b1;
                if (ca_word_sel_o == 2'(hyperbus_pkg::CA_WORDS - 1)) state_d = ST_LAT;
            end
            ST_LAT: begin
                bus_o.ck_en = 1'b1;
                if (lat_cnt_q == 5'd1) state_d = ST_DATA;
            end
            ST_DATA, ST_STALL: begin
                if (trans_q.write) begin
                    bus_o.dq      = txq_word_i.data;
                    bus_o.rwds    = ~txq_word_i.strb;
                    bus_o.dq_oe   = 1'b1;
                    bus_o.rwds_oe = 1'b1;
                end else begin
                    rxq_push_o = bus_i.rwds; // reply to an earlier clocked cycle
                end
                if (state_q == ST_DATA && data_go) begin
                    bus_o.ck_en = 1'b1;
                    txq_ready_o = trans_q.write;
                end
                if (state_q == ST_DATA && !data_go) state_d = ST_STALL;
                if (state_q == ST_STALL && data_go) state_d = ST_DATA;
                if (word_fire && last_word) state_d = ST_REC;
            end
            ST_ERR: begin
                if (trans_q.write) begin
                    txq_ready_o = 1'b1; // drop what is left of the burst
                end else begin
                    rxq_push_o       = rxq_space_i != '0;
                    rxq_word_o.data  = '0;
                    rxq_word_o.error = 1'b1;
                end
                if (word_fire && last_word) state_d = ST_REC;
            end
            ST_REC: begin
                if (rwr_cnt_q <= 4'd1) state_d = ST_IDLE;
            end
            default: state_d = ST_IDLE;
        endcase

        // a burst that finishes in the expiry cycle still ends normally
        if (expire && state_d != ST_REC) state_d = ST_ERR;
    end

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q       <= ST_IDLE;
            cs_n_q        <= '1;
            cs_timer_q    <= '0;
            ca_word_sel_o <= '0;
            lat_cnt_q     <= '0;
            beat_cnt_q    <= '0;
            word_cnt_q    <= '0;
            rwr_cnt_q     <= '0;
            b_valid_q     <= 1'b0;
            b_error_q     <= 1'b0;
        end else begin
            state_q    <= state_d;
            cs_timer_q <= cs_active ? cs_timer_q - 16'd1 : cfg_i.t_cs_max;
            b_valid_q  <= 1'b0;
            b_error_q  <= 1'b0;

            if (state_q == ST_IDLE && trans_valid_i) begin
                cs_n_q        <= ~trans_i.cs;
                ca_word_sel_o <= '0;
                beat_cnt_q    <= trans_i.burst;
                word_cnt_q    <= trans_i.burst;
            end
            if (state_q == ST_CMD) begin
                ca_word_sel_o <= ca_word_sel_o + 2'd1;
                // rwds from the memory asks for double latency
                lat_cnt_q <= bus_i.rwds ? {cfg_i.t_latency, 1'b0} : {1'b0, cfg_i.t_latency};
            end
            if (state_q == ST_LAT) lat_cnt_q <= lat_cnt_q - 5'd1;
            if (state_q == ST_DATA && bus_o.ck_en) beat_cnt_q <= beat_cnt_q - 1'b1;
            if (word_fire) word_cnt_q <= word_cnt_q - 1'b1;

            if (state_d == ST_ERR && state_q != ST_ERR) cs_n_q <= '1;
            if (state_d == ST_REC && state_q != ST_REC) begin
                cs_n_q    <= '1;
                rwr_cnt_q <= cfg_i.t_rwr;
                b_valid_q <= trans_q.write;
                b_error_q <= trans_q.write && state_q == ST_ERR;
            end
            if (state_q == ST_REC) rwr_cnt_q <= rwr_cnt_q - 4'd1;
        end
    end

    always_ff @(posedge clk0) begin
        if (trans_valid_i && trans_ready_o) trans_q <= trans_i;
    end

    // no device selected between bursts
    assert property (@(posedge clk0) disable iff (!rst_ni)
        state_q == ST_IDLE |-> &bus_o.cs_n);

    assert property (@(posedge clk0) disable iff (!rst_ni)
        !(&bus_o.cs_n) |-> $onehot(~bus_o.cs_n));

    // read FIFO must always have room for a captured word
    assert property (@(posedge clk0) disable iff (!rst_ni)
        rxq_push_o |-> rxq_space_i != '0);

endmodule

// ==== hw/hyperbus_phy.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HyperBus controller top, clk0 only
// bus clock is given as ck_en per word
// cfg_i must not change unless idle
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module hyperbus_phy (
    input  logic                   clk0,
    input  logic                   rst_ni,
    input  hyperbus_pkg::cfg_t     cfg_i,

    input  logic                   trans_valid_i,
    output logic                   trans_ready_o,
    input  hyperbus_pkg::trans_t   trans_i,

    input  logic                   tx_valid_i,
    output logic                   tx_ready_o,
    input  hyperbus_pkg::tx_word_t tx_i,

    output logic                   rx_valid_o,
    input  logic                   rx_ready_i,
    output hyperbus_pkg::rx_word_t rx_o,

    output logic                   b_valid_o,
    output logic                   b_error_o,

    output hyperbus_pkg::bus_out_t bus_o,
    input  hyperbus_pkg::bus_in_t  bus_i
);

    hyperbus_pkg::trans_t   cur_trans;
    logic [1:0]             ca_sel;
    logic [hyperbus_pkg::WORD_WIDTH-1:0] ca_word;

    logic                   txq_valid;
    logic                   txq_ready;
    logic                   txq_flush;
    hyperbus_pkg::tx_word_t txq_word;

    logic                   rxq_push;
    hyperbus_pkg::rx_word_t rxq_word;
    logic [hyperbus_pkg::SPACE_WIDTH-1:0] rxq_space;

    hyperbus_ctrl i_ctrl (
        .clk0          ( clk0          ),
        .rst_ni        ( rst_ni        ),
        .cfg_i         ( cfg_i         ),
        .trans_valid_i ( trans_valid_i ),
        .trans_ready_o ( trans_ready_o ),
        .trans_i       ( trans_i       ),
        .trans_o       ( cur_trans     ),
        .ca_word_sel_o ( ca_sel        ),
        .ca_word_i     ( ca_word       ),
        .txq_valid_i   ( txq_valid     ),
        .txq_ready_o   ( txq_ready     ),
        .txq_word_i    ( txq_word      ),
        .txq_flush_o   ( txq_flush     ),
        .rxq_push_o    ( rxq_push      ),
        .rxq_word_o    ( rxq_word      ),
        .rxq_space_i   ( rxq_space     ),
        .b_valid_o     ( b_valid_o     ),
        .b_error_o     ( b_error_o     ),
        .bus_o         ( bus_o         ),
        .bus_i         ( bus_i         )
    );

    hyperbus_ca_gen i_ca_gen (
        .trans_i    ( cur_trans ),
        .word_sel_i ( ca_sel    ),
        .ca_word_o  ( ca_word   )
    );

    // write words, open only during a write burst
    hyperbus_word_fifo #(.payload_t(hyperbus_pkg::tx_word_t)) i_tx_fifo (
        .clk0         ( clk0       ),
        .rst_ni       ( rst_ni     ),
        .flush_i      ( txq_flush  ),
        .push_valid_i ( tx_valid_i ),
        .push_ready_o ( tx_ready_o ),
        .push_data_i  ( tx_i       ),
        .pop_valid_o  ( txq_valid  ),
        .pop_ready_i  ( txq_ready  ),
        .pop_data_o   ( txq_word   ),
        .space_o      (            )
    );

    // captured read words, kept until the user drains them
    hyperbus_word_fifo #(.payload_t(hyperbus_pkg::rx_word_t)) i_rx_fifo (
        .clk0         ( clk0       ),
        .rst_ni       ( rst_ni     ),
        .flush_i      ( 1'b0       ),
        .push_valid_i ( rxq_push   ),
        .push_ready_o (            ),
        .push_data_i  ( rxq_word   ),
        .pop_valid_o  ( rx_valid_o ),
        .pop_ready_i  ( rx_ready_i ),
        .pop_data_o   ( rx_o       ),
        .space_o      ( rxq_space  )
    );

endmodule

// ==== verification/hyperbus_mem_model.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// behavioural HyperBus memory, 256 words
// knows its latency from t_latency/rwds
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module hyperbus_mem_model (
    input  logic                   clk0,
    input  logic                   rst_ni,
    input  hyperbus_pkg::bus_out_t pins_i,
    output hyperbus_pkg::bus_in_t  pins_o,
    input  logic [3:0]             t_latency_i,
    input  logic                   rwds_high_i,
    output logic [31:0]            addr_o,
    output logic                   write_o,
    output int                     wait_o,
    output int                     err_o
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [15:0] mem [256];
    logic [31:0] ca_q;
    int          ca_cnt;
    int          beat;
    int          lat;
    logic        resp_q;
    logic [15:0] resp_dq;
    logic [47:0] ca;

    assign lat = rwds_high_i ? 2 * int'(t_latency_i) : int'(t_latency_i);
    assign ca  = {ca_q, pins_i.dq};
    // rwds high during the command asks for double latency
    assign pins_o.rwds = resp_q || (!(&pins_i.cs_n) && ca_cnt < 3 && rwds_high_i);
    assign pins_o.dq   = resp_dq;

    initial begin
        for (int i = 0; i < 256; i++) mem[i] = 16'(i * 40503 + 7); // address-wide fill
    end

    always @(posedge clk0 or negedge rst_ni) begin
        logic [7:0] idx;
        if (!rst_ni) begin
            ca_cnt  <= 0;
            beat    <= 0;
            resp_q  <= 1'b0;
            resp_dq <= '0;
            wait_o  <= 0;
            err_o   <= 0;
            addr_o  <= '0;
            write_o <= 1'b0;
        end else begin
            resp_q <= 1'b0;
            if (&pins_i.cs_n) begin
                ca_cnt <= 0;
                beat   <= 0;
            end else if (pins_i.ck_en && ca_cnt < 3) begin
                if (pins_i.dq_oe !== 1'b1) begin
                    $display("[FAIL] %0t: command word %0d not driven", $time, ca_cnt);
                    err_o <= err_o + 1;
                end
                ca_q   <= {ca_q[15:0], pins_i.dq};
                ca_cnt <= ca_cnt + 1;
                if (ca_cnt == 2) begin
                    if (ca[46] !== 1'b0 || ca[45] !== 1'b1 || ca[15:3] !== '0) begin
                        $display("[FAIL] %0t: bad command-address %012h", $time, ca);
                        err_o <= err_o + 1;
                    end
                    addr_o  <= {ca[44:16], ca[2:0]};
                    write_o <= !ca[47];
                    wait_o  <= 0;
                end
            end else if (pins_i.ck_en && pins_i.rwds_oe) begin
                idx = 8'(addr_o + beat);
                if (!pins_i.rwds[1]) mem[idx][15:8] <= pins_i.dq[15:8];
                if (!pins_i.rwds[0]) mem[idx][7:0] <= pins_i.dq[7:0];
                beat <= beat + 1;
            end else if (pins_i.ck_en) begin
                wait_o <= wait_o + 1;
                if (!write_o && wait_o >= lat) begin // answer in the next cycle
                    idx     = 8'(addr_o + 32'(wait_o - lat));
                    resp_q  <= 1'b1;
                    resp_dq <= mem[idx];
                end
            end
        end
    end

endmodule

// ==== verification/tb_hyperbus_phy.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// table driven testbench, t_latency 3
// memory model sees addresses mod 256
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_hyperbus_phy;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NR_ROWS = 9;
    localparam int TIMEOUT = 2000;

    typedef struct packed {
        logic        write;
        logic [31:0] addr;
        logic [11:0] burst;
        logic        rwds_high;
        logic        rx_stall;
        logic        tx_gap;
        logic [15:0] t_cs_max;
        logic        expect_error;
    } row_t;

    logic clk0 = 1'b0;
    logic rst_ni;
    hyperbus_pkg::cfg_t     cfg;
    logic                   trans_valid_i, trans_ready_o;
    hyperbus_pkg::trans_t   trans;
    logic                   tx_valid_i, tx_ready_o;
    hyperbus_pkg::tx_word_t tx_i;
    logic                   rx_valid_o, rx_ready_i;
    hyperbus_pkg::rx_word_t rx_o;
    logic                   b_valid_o, b_error_o;
    hyperbus_pkg::bus_out_t bus_o;
    hyperbus_pkg::bus_in_t  bus_i;
    logic                   rwds_high;

    row_t        rows [NR_ROWS];
    logic [15:0] exp_mem [256];
    logic [1:0]  exp_known [256]; // per byte
    logic [31:0] seed = 32'hab93977a;
    int          errors, timeouts, b_cnt;
    logic        b_err;
    logic [hyperbus_pkg::NR_CS-1:0] cs_low;
    logic [31:0] mdl_addr;
    logic        mdl_write;
    int          mdl_wait, mdl_err;

    always #10 clk0 = ~clk0;

    hyperbus_phy DUT (
        .clk0, .rst_ni, .cfg_i(cfg), .trans_valid_i, .trans_ready_o, .trans_i(trans),
        .tx_valid_i, .tx_ready_o, .tx_i, .rx_valid_o, .rx_ready_i, .rx_o,
        .b_valid_o, .b_error_o, .bus_o, .bus_i
    );

    hyperbus_mem_model i_mem (
        .clk0, .rst_ni, .pins_i(bus_o), .pins_o(bus_i), .t_latency_i(cfg.t_latency),
        .rwds_high_i(rwds_high), .addr_o(mdl_addr), .write_o(mdl_write),
        .wait_o(mdl_wait), .err_o(mdl_err)
    );

    always @(negedge clk0) begin
        if (rst_ni && b_valid_o) begin
            b_cnt++;
            b_err = b_error_o;
        end
        if (rst_ni && !(&bus_o.cs_n)) cs_low = cs_low | ~bus_o.cs_n; // lines seen low
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (!trans_ready_o && n < TIMEOUT) begin
            @(negedge clk0);
            n++;
        end
        if (!trans_ready_o) begin
            timeouts++;
            $display("timeout: controller did not return to idle at %0t", $time);
        end
    endtask

    task automatic send_words(input row_t r);
        int n;
        logic [31:0] rnd;
        logic [7:0] idx;
        for (int i = 0; i < int'(r.burst); i++) begin
            if (r.tx_gap && lcg_next() % 3 == 0) @(negedge clk0); // idle gap
            rnd = lcg_next();
            tx_i.data = rnd[15:0];
            tx_i.strb = rnd[17:16];
            tx_valid_i = 1'b1;
            n = 0;
            while (!tx_ready_o && n < TIMEOUT) begin
                @(negedge clk0);
                n++;
            end
            if (!tx_ready_o) begin
                timeouts++;
                $display("timeout: write word %0d was never accepted", i);
                tx_valid_i = 1'b0;
                return;
            end
            idx = 8'(r.addr + 32'(i));
            if (tx_i.strb[1]) exp_mem[idx][15:8] = tx_i.data[15:8];
            if (tx_i.strb[0]) exp_mem[idx][7:0] = tx_i.data[7:0];
            exp_known[idx] = exp_known[idx] | tx_i.strb;
            @(negedge clk0);
            tx_valid_i = 1'b0;
        end
    endtask

    task automatic collect_words(input row_t r);
        int cnt, n;
        logic seen_err;
        logic [7:0] idx;
        logic [15:0] mask;
        cnt = 0;
        n = 0;
        seen_err = 1'b0;
        while (cnt < int'(r.burst) && n < TIMEOUT) begin
            rx_ready_i = !r.rx_stall || lcg_next() % 2 == 0;
            if (rx_valid_o && rx_ready_i) begin
                idx = 8'(r.addr + 32'(cnt));
                check("rx last", 32'(rx_o.last), 32'(cnt == int'(r.burst) - 1));
                if (rx_o.error) seen_err = 1'b1;
                check("rx error", 32'(rx_o.error), 32'(seen_err && r.expect_error));
                if (!rx_o.error) begin
                    mask = {{8{exp_known[idx][1]}}, {8{exp_known[idx][0]}}};
                    check("rx data", 32'(rx_o.data & mask), 32'(exp_mem[idx] & mask));
                end
                cnt++;
            end
            @(negedge clk0);
            n++;
        end
        rx_ready_i = 1'b0;
        if (cnt < int'(r.burst)) begin
            timeouts++;
            $display("timeout: only %0d of %0d read words arrived", cnt, r.burst);
        end
        if (r.expect_error) check("rx error seen", 32'(seen_err), 32'd1);
    endtask

    task automatic run_row(input row_t r, input int k);
        int exp_wait;
        wait_idle();
        cfg.t_cs_max  = r.t_cs_max;
        rwds_high     = r.rwds_high;
        trans.address = r.addr;
        trans.cs      = (k % 2 == 1) ? 2'b10 : 2'b01;
        trans.write   = r.write;
        trans.burst   = r.burst;
        trans.wrapped = 1'b0;
        b_cnt         = 0;
        cs_low        = '0;
        trans_valid_i = 1'b1; // idle, so taken at the next rising edge
        @(negedge clk0);
        trans_valid_i = 1'b0;
        if (r.write) send_words(r);
        else collect_words(r);
        wait_idle();
        check("chip select", 32'(cs_low), 32'(trans.cs));
        check("decoded address", mdl_addr, r.addr);
        check("decoded write", 32'(mdl_write), 32'(r.write));
        check("b pulses", b_cnt, 32'(r.write));
        if (r.write) check("b error", 32'(b_err), 32'(r.expect_error));
        check("rx left over", 32'(rx_valid_o), 32'd0);
        if (!r.expect_error) begin
            exp_wait = r.rwds_high ? 2 * int'(cfg.t_latency) : int'(cfg.t_latency);
            if (!r.write) exp_wait += int'(r.burst); // read data cycles are clocked too
            check("wait cycles", mdl_wait, exp_wait);
        end
        // a cut write leaves the range partly written
        if (r.write && r.expect_error) begin
            for (int i = 0; i < int'(r.burst); i++) exp_known[8'(r.addr + 32'(i))] = 2'b00;
        end
    endtask

    initial begin
        errors = 0;
        timeouts = 0;
        b_cnt = 0;
        b_err = 1'b0;
        cs_low = '0;
        rst_ni = 1'b0;
        cfg = '{t_latency: 4'd3, t_rwr: 4'd2, t_cs_max: 16'd200, rwds_ignore: 4'd0};
        trans_valid_i = 1'b0;
        trans = '0;
        tx_valid_i = 1'b0;
        tx_i = '0;
        rx_ready_i = 1'b0;
        rwds_high = 1'b0;
        for (int i = 0; i < 256; i++) exp_known[i] = 2'b00;
        //            write  addr    burst  rwds  stall gap   cs_max  err
        rows[0] = '{1'b1, 32'd16,  12'd4, 1'b0, 1'b0, 1'b0, 16'd200, 1'b0};
        rows[1] = '{1'b0, 32'd16,  12'd4, 1'b1, 1'b0, 1'b0, 16'd200, 1'b0};
        rows[2] = '{1'b1, 32'd40,  12'd6, 1'b1, 1'b0, 1'b1, 16'd200, 1'b0};
        rows[3] = '{1'b0, 32'd40,  12'd6, 1'b0, 1'b1, 1'b0, 16'd200, 1'b0};
        rows[4] = '{1'b0, 32'd16,  12'd8, 1'b0, 1'b0, 1'b0, 16'd10,  1'b1};
        rows[5] = '{1'b0, 32'd40,  12'd6, 1'b1, 1'b1, 1'b0, 16'd200, 1'b0};
        rows[6] = '{1'b1, 32'd100, 12'd8, 1'b0, 1'b0, 1'b0, 16'd10,  1'b1};
        rows[7] = '{1'b1, 32'd100, 12'd8, 1'b0, 1'b0, 1'b1, 16'd200, 1'b0};
        rows[8] = '{1'b0, 32'd100, 12'd8, 1'b1, 1'b1, 1'b0, 16'd200, 1'b0};
        repeat (3) @(posedge clk0);
        @(negedge clk0);
        // outputs inactive while in reset
        check("reset outputs",
              32'({bus_o.cs_n, bus_o.ck_en, bus_o.dq_oe, bus_o.rwds_oe, tx_ready_o,
                   rx_valid_o, b_valid_o, trans_ready_o}),
              32'({{hyperbus_pkg::NR_CS{1'b1}}, 7'b0000001}));
        rst_ni = 1'b1;
        for (int k = 0; k < NR_ROWS; k++) run_row(rows[k], k);
        check("model command errors", mdl_err, 0);
        $display("summary: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== hyperbus_phy.f ====
common/hyperbus_pkg.sv
hw/hyperbus_word_fifo.sv
hw/hyperbus_ca_gen.sv
hyperbus_ctrl/hyperbus_ctrl.sv
hw/hyperbus_phy.sv
verification/hyperbus_mem_model.sv
verification/tb_hyperbus_phy.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds and runs the HyperBus testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f hyperbus_phy.f --top-module tb_hyperbus_phy -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/Vtb_hyperbus_phy > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* TEST FAILED \*\*\*' sim.log; then
    exit 1
fi
exit 0
